// ==== verilog/msx_frontend_consts.svh ====
// MSX frontend constants
// Status word bit positions, bus widths and fixed numbers shared by the
// control glue blocks

`ifndef MSX_FRONTEND_CONSTS_SVH
`define MSX_FRONTEND_CONSTS_SVH

// ========================================
// Status word layout
// ========================================
`define STATUS_W             64
`define ST_RESET             0
`define ST_ASPECT_LO         1
`define ST_SCALE_LO          3
`define ST_TAPE_REWIND       9
`define ST_DETACH            10
`define ST_SRAM_SAVE         38
`define ST_SRAM_LOAD         39
`define ST_TAPE_ADC          40

// ========================================
// Widths and fixed numbers
// ========================================
`define DDR_ADDR_W           28
`define ACT_TIMEOUT_DEFAULT  1000000
`define CAS_INDEX            5
`define HDMI_FULL_W          1920
`define HDMI_FULL_H          1080
`define CROP_LINES           216
`define IMG_SIZE_W           64

`endif

// ==== verilog/msx_frontend_pkg.sv ====
// MSX frontend types
// Packed structs for the scaler settings, SD pins, LEDs and DDR3 read requests

`default_nettype none

`include "msx_frontend_consts.svh"

package msx_frontend_pkg;

   // Scaler and aspect settings
   typedef struct packed {
      logic [11:0] arx;
      logic [11:0] ary;
      logic [11:0] crop_size;
      logic [1:0]  vga_sl;
      logic        hq2x;
      logic        scandoubler;
   } video_cfg_t;

   // Physical SD card outputs
   typedef struct packed {
      logic cs;
      logic sck;
      logic mosi;
   } sd_pins_t;

   // Board LEDs
   // disk[1] set means the core alone owns the disk LED
   typedef struct packed {
      logic       user;
      logic [1:0] disk;
      logic [1:0] power;
   } led_t;

   // One DDR3 read request, byte address plus read flag
   typedef struct packed {
      logic [`DDR_ADDR_W-1:0] addr;
      logic                   rd;
   } ddr_rd_req_t;

endpackage

`default_nettype wire

// ==== verilog/status_decode.sv ====
// Status word decoder
// Builds the registered core reset and turns the battery RAM save/load
// levels into single-cycle strobes

`timescale 1ns/1ps
`default_nettype none

`include "msx_frontend_consts.svh"

module status_decode import msx_frontend_pkg::*; (
   input  wire logic                 clock_bus,
   input  wire logic                 reset,
   input  wire logic                 upload_reset,
   input  wire logic                 load_sram,
   input  wire logic [`STATUS_W-1:0] status,
   output logic                      core_reset,
   output logic                      sram_save_stb,
   output logic                      sram_load_stb
);

   logic save_req;
   logic load_req;
   logic save_q;
   logic load_q;

   assign save_req = status[`ST_SRAM_SAVE];
   // Menu load or loader request, either one starts a load
   assign load_req = status[`ST_SRAM_LOAD] | load_sram;

   // Reset sources merged, one cycle late
   always_ff @(posedge clock_bus) begin
      if (reset) begin
         core_reset <= 1'b1;
      end else begin
         core_reset <= status[`ST_RESET] | status[`ST_DETACH] | upload_reset;
      end
   end

   // Previous levels for edge detection
   always_ff @(posedge clock_bus) begin
      save_q <= save_req;
      load_q <= load_req;
   end

   always_ff @(posedge clock_bus) begin
      if (reset) begin
         sram_save_stb <= 1'b0;
         sram_load_stb <= 1'b0;
      end else begin
         sram_save_stb <= save_req & ~save_q;
         sram_load_stb <= load_req & ~load_q;
      end
   end

   // Strobes never stretch over two cycles
   a_save_single: assert property (@(posedge clock_bus) disable iff (reset)
      sram_save_stb |=> !sram_save_stb);
   a_load_single: assert property (@(posedge clock_bus) disable iff (reset)
      sram_load_stb |=> !sram_load_stb);

endmodule

`default_nettype wire

// ==== verilog/video_scaler_setup.sv ====
// Video scaler setup
// Decodes aspect ratio, scanlines, hq2x, scandoubler and the 216-line
// crop into one registered settings word

`timescale 1ns/1ps
`default_nettype none

`include "msx_frontend_consts.svh"

module video_scaler_setup import msx_frontend_pkg::*; (
   input  wire logic                 clock_bus,
   input  wire logic                 reset,
   input  wire logic                 forced_scandoubler,
   input  wire logic [`STATUS_W-1:0] status,
   input  wire logic [11:0]          hdmi_width,
   input  wire logic [11:0]          hdmi_height,
   output video_cfg_t                video_cfg
);

   logic [1:0] ar;
   logic [2:0] scale;
   logic [2:0] sl;
   logic       full_hd;
   video_cfg_t cfg_next;

   assign ar    = status[`ST_ASPECT_LO +: 2];
   assign scale = status[`ST_SCALE_LO +: 3];
   assign sl    = (scale != 3'd0) ? scale - 3'd1 : 3'd0;

   assign full_hd = (hdmi_width == 12'(`HDMI_FULL_W)) && (hdmi_height == 12'(`HDMI_FULL_H));

   always_comb begin
      // Original 4:3, or one of the full-screen / custom ratios
      cfg_next.arx = (ar == 2'd0) ? 12'd4 : {10'b0, ar - 2'd1};
      cfg_next.ary = (ar == 2'd0) ? 12'd3 : 12'd0;
      // 216p crop only makes sense on a real 1080p output
      cfg_next.crop_size = (full_hd && !forced_scandoubler && scale != 3'd0) ?
                           12'(`CROP_LINES) : 12'd0;
      cfg_next.vga_sl      = sl[1:0];
      cfg_next.hq2x        = (scale == 3'd1);
      cfg_next.scandoubler = (scale != 3'd0) || forced_scandoubler;
   end

   always_ff @(posedge clock_bus) begin
      if (reset) begin
         video_cfg <= '0;
      end else begin
         video_cfg <= cfg_next;
      end
   end

   a_hq2x_needs_sd: assert property (@(posedge clock_bus) disable iff (reset)
      video_cfg.hq2x |-> video_cfg.scandoubler);

endmodule

`default_nettype wire

// ==== verilog/sd_card_router.sv ====
// SD card router
// Selects the virtual image or the physical card, gates the card pins
// and drives the activity LEDs from a saturating timer

`timescale 1ns/1ps
`default_nettype none

`include "msx_frontend_consts.svh"

module sd_card_router import msx_frontend_pkg::*; #(
   parameter int act_timeout = `ACT_TIMEOUT_DEFAULT
) (
   input  wire logic                   clock_bus,
   input  wire logic                   reset,
   input  wire logic                   img_mounted_stb,
   input  wire logic                   spi_clk,
   input  wire logic                   spi_mosi,
   input  wire logic                   sd_miso,
   input  wire logic                   vsd_miso,
   input  wire logic [`IMG_SIZE_W-1:0] img_size,
   output sd_pins_t                    sd_pins,
   output logic                        sd_miso_core,
   output led_t                        leds
);

   localparam int TMR_W = $clog2(act_timeout + 1);
   localparam logic [TMR_W-1:0] ACT_MAX = TMR_W'(act_timeout);

   logic             vsd_sel;
   logic             mosi_q;
   logic             miso_q;
   logic             spi_change;
   logic [TMR_W-1:0] act_timer;
   logic             sd_act;

   // ========================================
   // Card select and pin gating
   // ========================================
   always_ff @(posedge clock_bus) begin
      if (reset) begin
         vsd_sel <= 1'b0;
      end else if (img_mounted_stb) begin
         vsd_sel <= |img_size;
      end
   end

   // Physical card stays deselected while the image is in use
   assign sd_pins.cs   = vsd_sel;
   assign sd_pins.sck  = spi_clk & ~vsd_sel;
   assign sd_pins.mosi = spi_mosi & ~vsd_sel;
   assign sd_miso_core = vsd_sel ? vsd_miso : sd_miso;

   // ========================================
   // Activity timer
   // ========================================
   always_ff @(posedge clock_bus) begin
      mosi_q <= spi_mosi;
      miso_q <= sd_miso_core;
   end

   assign spi_change = (mosi_q ^ spi_mosi) | (miso_q ^ sd_miso_core);

   always_ff @(posedge clock_bus) begin
      if (reset) begin
         act_timer <= ACT_MAX;
         sd_act    <= 1'b0;
      end else begin
         sd_act <= (act_timer < ACT_MAX);
         if (spi_change) begin
            act_timer <= '0;
         end else if (act_timer < ACT_MAX) begin
            act_timer <= act_timer + 1'b1;
         end
      end
   end

   assign leds.user  = vsd_sel & sd_act;
   assign leds.disk  = {1'b1, ~vsd_sel & sd_act};
   assign leds.power = 2'b00;

   a_pins_quiet: assert property (@(posedge clock_bus) disable iff (reset)
      sd_pins.cs |-> (!sd_pins.sck && !sd_pins.mosi));

endmodule

`default_nettype wire

// ==== verilog/cassette_control.sv ====
// Cassette control
// Arms playback after a tape download, forms play and rewind, picks the
// tape input and shares the DDR3 read port with the file loader

`timescale 1ns/1ps
`default_nettype none

`include "msx_frontend_consts.svh"

module cassette_control import msx_frontend_pkg::*; (
   input  wire logic                 clock_bus,
   input  wire logic                 reset,
   input  wire logic                 core_reset,
   input  wire logic                 ioctl_download,
   input  wire logic                 motor,
   input  wire logic                 cas_dout,
   input  wire logic                 tape_adc,
   input  wire logic                 tape_adc_act,
   input  wire logic                 dl_active,
   input  wire logic [15:0]          ioctl_index,
   input  wire logic [`STATUS_W-1:0] status,
   input  wire ddr_rd_req_t          dl_req,
   input  wire ddr_rd_req_t          cas_req,
   output logic                      cas_enable,
   output logic                      play,
   output logic                      rewind,
   output logic                      tape_in,
   output ddr_rd_req_t               ddr_req
);

   logic cas_dl;
   logic cas_dl_q;

   assign cas_dl = ioctl_download & (ioctl_index == 16'(`CAS_INDEX));

   // Falling edge of a tape download arms the player until reset
   always_ff @(posedge clock_bus) begin
      if (reset) begin
         cas_dl_q   <= 1'b0;
         cas_enable <= 1'b0;
      end else begin
         cas_dl_q <= cas_dl;
         if (cas_dl_q & ~cas_dl) begin
            cas_enable <= 1'b1;
         end
      end
   end

   // Motor is active low from the PPI
   assign play   = ~motor & cas_enable;
   assign rewind = status[`ST_TAPE_REWIND] | cas_dl | core_reset;

   // File player or the ADC line input
   assign tape_in = status[`ST_TAPE_ADC] ? (tape_adc & tape_adc_act) : cas_dout;

   // Loader wins the read port while it runs
   assign ddr_req = dl_active ? dl_req : cas_req;

   a_loader_priority: assert property (@(posedge clock_bus) disable iff (reset)
      dl_active |-> (ddr_req == dl_req));

endmodule

`default_nettype wire

// ==== verilog/msx_frontend.sv ====
// MSX frontend top level
// Board-side control glue: status decode, scaler setup, SD routing and
// cassette control side by side

`timescale 1ns/1ps
`default_nettype none

`include "msx_frontend_consts.svh"

module msx_frontend import msx_frontend_pkg::*; #(
   parameter int act_timeout = `ACT_TIMEOUT_DEFAULT
) (
   input  wire logic                   clock_bus,
   input  wire logic                   reset,
   input  wire logic [`STATUS_W-1:0]   status,
   // Reset and battery RAM
   input  wire logic                   upload_reset,
   input  wire logic                   load_sram,
   output logic                        core_reset,
   output logic                        sram_save_stb,
   output logic                        sram_load_stb,
   // Video
   input  wire logic                   forced_scandoubler,
   input  wire logic [11:0]            hdmi_width,
   input  wire logic [11:0]            hdmi_height,
   output video_cfg_t                  video_cfg,
   // SD card
   input  wire logic                   img_mounted_stb,
   input  wire logic [`IMG_SIZE_W-1:0] img_size,
   input  wire logic                   spi_clk,
   input  wire logic                   spi_mosi,
   input  wire logic                   sd_miso,
   input  wire logic                   vsd_miso,
   output sd_pins_t                    sd_pins,
   output logic                        sd_miso_core,
   output led_t                        leds,
   // Cassette and DDR3 read port
   input  wire logic                   ioctl_download,
   input  wire logic [15:0]            ioctl_index,
   input  wire logic                   motor,
   input  wire logic                   cas_dout,
   input  wire logic                   tape_adc,
   input  wire logic                   tape_adc_act,
   input  wire logic                   dl_active,
   input  wire ddr_rd_req_t            dl_req,
   input  wire ddr_rd_req_t            cas_req,
   output logic                        cas_enable,
   output logic                        play,
   output logic                        rewind,
   output logic                        tape_in,
   output ddr_rd_req_t                 ddr_req
);

   status_decode u_status_decode (
      .clock_bus     (clock_bus),
      .reset         (reset),
      .upload_reset  (upload_reset),
      .load_sram     (load_sram),
      .status        (status),
      .core_reset    (core_reset),
      .sram_save_stb (sram_save_stb),
      .sram_load_stb (sram_load_stb)
   );

   video_scaler_setup u_video_scaler_setup (
      .clock_bus          (clock_bus),
      .reset              (reset),
      .forced_scandoubler (forced_scandoubler),
      .status             (status),
      .hdmi_width         (hdmi_width),
      .hdmi_height        (hdmi_height),
      .video_cfg          (video_cfg)
   );

   sd_card_router #(
      .act_timeout (act_timeout)
   ) u_sd_card_router (
      .clock_bus       (clock_bus),
      .reset           (reset),
      .img_mounted_stb (img_mounted_stb),
      .spi_clk         (spi_clk),
      .spi_mosi        (spi_mosi),
      .sd_miso         (sd_miso),
      .vsd_miso        (vsd_miso),
      .img_size        (img_size),
      .sd_pins         (sd_pins),
      .sd_miso_core    (sd_miso_core),
      .leds            (leds)
   );

   cassette_control u_cassette_control (
      .clock_bus      (clock_bus),
      .reset          (reset),
      .core_reset     (core_reset),
      .ioctl_download (ioctl_download),
      .motor          (motor),
      .cas_dout       (cas_dout),
      .tape_adc       (tape_adc),
      .tape_adc_act   (tape_adc_act),
      .dl_active      (dl_active),
      .ioctl_index    (ioctl_index),
      .status         (status),
      .dl_req         (dl_req),
      .cas_req        (cas_req),
      .cas_enable     (cas_enable),
      .play           (play),
      .rewind         (rewind),
      .tape_in        (tape_in),
      .ddr_req        (ddr_req)
   );

endmodule

`default_nettype wire

// ==== bench/tb_msx_frontend.sv ====
// MSX frontend testbench
// Table-driven checks of the status decode, scaler setup, SD routing,
// cassette control and DDR3 read arbitration

`timescale 1ns/1ps
`default_nettype none

`include "msx_frontend_consts.svh"

module tb_msx_frontend import msx_frontend_pkg::*; ();

   localparam int ACT_TIMEOUT = 20;
   localparam int VIDEO_ROWS  = 12;
   localparam int STROBE_ROWS = 15;
   localparam int SD_ROWS     = 8;
   localparam int ACT_ROWS    = 2;
   localparam int CAS_ROWS    = 17;
   localparam int DDR_ROWS    = 32;
   localparam int TOTAL_ROWS  = VIDEO_ROWS + STROBE_ROWS + SD_ROWS + ACT_ROWS + CAS_ROWS
                                + DDR_ROWS;
   localparam int WATCHDOG_CYCLES = TOTAL_ROWS * 40;

   // ========================================
   // Table row types
   // ========================================
   typedef struct packed {
      logic [1:0]  ar;
      logic [2:0]  scale;
      logic [11:0] width;
      logic [11:0] height;
      logic        forced;
      video_cfg_t  exp;
   } video_row_t;

   // Drive bits are reset, upload_reset, load_sram, st_reset, st_detach, save, load
   // Expected bits are core_reset, sram_save_stb, sram_load_stb
   typedef struct packed {
      logic [6:0] drive;
      logic [2:0] exp;
   } strobe_row_t;

   typedef struct packed {
      logic        mount;
      logic [63:0] size;
      logic        exp_sel;
   } sd_row_t;

   // Activity window in cycles after the MOSI toggle
   typedef struct packed {
      logic       sel;
      logic [7:0] hi_from;
      logic [7:0] hi_to;
      logic [7:0] low_at;
   } act_row_t;

   // Control bits are motor, st_rewind, st_reset, st_adc, cas_dout, tape_adc, tape_adc_act
   // Expected bits are cas_enable, play, rewind, tape_in
   typedef struct packed {
      logic        download;
      logic [15:0] index;
      logic [6:0]  ctl;
      logic [3:0]  exp;
   } cas_row_t;

   typedef struct packed {
      logic        active;
      ddr_rd_req_t dl;
      ddr_rd_req_t cas;
      ddr_rd_req_t exp;
   } ddr_row_t;

   video_row_t video_tbl [VIDEO_ROWS] = '{
      '{2'd0, 3'd0, 12'd1920, 12'd1080, 1'b0, '{12'd4, 12'd3, 12'd0,   2'd0, 1'b0, 1'b0}},
      '{2'd1, 3'd0, 12'd1920, 12'd1080, 1'b0, '{12'd0, 12'd0, 12'd0,   2'd0, 1'b0, 1'b0}},
      '{2'd2, 3'd1, 12'd1920, 12'd1080, 1'b0, '{12'd1, 12'd0, 12'd216, 2'd0, 1'b1, 1'b1}},
      '{2'd3, 3'd2, 12'd1920, 12'd1080, 1'b0, '{12'd2, 12'd0, 12'd216, 2'd1, 1'b0, 1'b1}},
      '{2'd0, 3'd3, 12'd1920, 12'd1080, 1'b0, '{12'd4, 12'd3, 12'd216, 2'd2, 1'b0, 1'b1}},
      '{2'd0, 3'd4, 12'd1920, 12'd1080, 1'b0, '{12'd4, 12'd3, 12'd216, 2'd3, 1'b0, 1'b1}},
      '{2'd1, 3'd5, 12'd1920, 12'd1080, 1'b1, '{12'd0, 12'd0, 12'd0,   2'd0, 1'b0, 1'b1}},
      '{2'd0, 3'd0, 12'd1920, 12'd1080, 1'b1, '{12'd4, 12'd3, 12'd0,   2'd0, 1'b0, 1'b1}},
      '{2'd2, 3'd1, 12'd1280, 12'd720,  1'b0, '{12'd1, 12'd0, 12'd0,   2'd0, 1'b1, 1'b1}},
      '{2'd0, 3'd6, 12'd1920, 12'd1200, 1'b0, '{12'd4, 12'd3, 12'd0,   2'd1, 1'b0, 1'b1}},
      '{2'd3, 3'd7, 12'd1920, 12'd1080, 1'b0, '{12'd2, 12'd0, 12'd216, 2'd2, 1'b0, 1'b1}},
      '{2'd0, 3'd1, 12'd1920, 12'd1080, 1'b1, '{12'd4, 12'd3, 12'd0,   2'd0, 1'b1, 1'b1}}
   };

   strobe_row_t strobe_tbl [STROBE_ROWS] = '{
      '{7'b1000000, 3'b100},
      '{7'b0000000, 3'b000},
      '{7'b0001000, 3'b100},
      '{7'b0000000, 3'b000},
      '{7'b0000100, 3'b100},
      '{7'b0100000, 3'b100},
      '{7'b0000000, 3'b000},
      '{7'b0000010, 3'b010},
      '{7'b0000010, 3'b000},
      '{7'b0000011, 3'b001},
      '{7'b0000011, 3'b000},
      '{7'b0000000, 3'b000},
      '{7'b0010000, 3'b001},
      '{7'b0000000, 3'b000},
      '{7'b0010000, 3'b001}
   };

   sd_row_t sd_tbl [SD_ROWS] = '{
      '{1'b1, 64'h0,                 1'b0},
      '{1'b1, 64'h1000,              1'b1},
      '{1'b0, 64'h0,                 1'b1},
      '{1'b1, 64'h8000_0000_0000_0000, 1'b1},
      '{1'b1, 64'h0,                 1'b0},
      '{1'b0, 64'h5,                 1'b0},
      '{1'b1, 64'h1,                 1'b1},
      '{1'b1, 64'h0,                 1'b0}
   };

   act_row_t act_tbl [ACT_ROWS] = '{
      '{1'b0, 8'd3, 8'd17, 8'd25},
      '{1'b1, 8'd3, 8'd17, 8'd25}
   };

   cas_row_t cas_tbl [CAS_ROWS] = '{
      '{1'b1, 16'd3, 7'b1000100, 4'b0001},
      '{1'b0, 16'd3, 7'b1000100, 4'b0001},
      '{1'b0, 16'd3, 7'b0000000, 4'b0000},
      '{1'b1, 16'd5, 7'b0000000, 4'b0010},
      '{1'b1, 16'd5, 7'b0000000, 4'b0010},
      '{1'b0, 16'd5, 7'b0000000, 4'b0000},
      '{1'b0, 16'd5, 7'b0000000, 4'b1100},
      '{1'b0, 16'd5, 7'b1000000, 4'b1000},
      '{1'b0, 16'd5, 7'b0100000, 4'b1110},
      '{1'b0, 16'd5, 7'b0001011, 4'b1101},
      '{1'b0, 16'd5, 7'b0001010, 4'b1100},
      '{1'b0, 16'd5, 7'b0001101, 4'b1100},
      '{1'b0, 16'd5, 7'b0000000, 4'b1100},
      '{1'b0, 16'd5, 7'b1010000, 4'b1000},
      '{1'b0, 16'd5, 7'b1010000, 4'b1010},
      '{1'b0, 16'd5, 7'b1000000, 4'b1010},
      '{1'b0, 16'd5, 7'b1000000, 4'b1000}
   };

   ddr_row_t ddr_tbl [DDR_ROWS];

   // ========================================
   // DUT and clock
   // ========================================
   logic                   clock_bus;
   logic                   reset;
   logic [`STATUS_W-1:0]   status;
   logic                   upload_reset;
   logic                   load_sram;
   logic                   core_reset;
   logic                   sram_save_stb;
   logic                   sram_load_stb;
   logic                   forced_scandoubler;
   logic [11:0]            hdmi_width;
   logic [11:0]            hdmi_height;
   video_cfg_t             video_cfg;
   logic                   img_mounted_stb;
   logic [`IMG_SIZE_W-1:0] img_size;
   logic                   spi_clk;
   logic                   spi_mosi;
   logic                   sd_miso;
   logic                   vsd_miso;
   sd_pins_t               sd_pins;
   logic                   sd_miso_core;
   led_t                   leds;
   logic                   ioctl_download;
   logic [15:0]            ioctl_index;
   logic                   motor;
   logic                   cas_dout;
   logic                   tape_adc;
   logic                   tape_adc_act;
   logic                   dl_active;
   ddr_rd_req_t            dl_req;
   ddr_rd_req_t            cas_req;
   logic                   cas_enable;
   logic                   play;
   logic                   rewind;
   logic                   tape_in;
   ddr_rd_req_t            ddr_req;

   logic [31:0] rng;
   int          checks;
   int          errors;

   msx_frontend #(
      .act_timeout (ACT_TIMEOUT)
   ) u_msx_frontend (
      .clock_bus          (clock_bus),
      .reset              (reset),
      .status             (status),
      .upload_reset       (upload_reset),
      .load_sram          (load_sram),
      .core_reset         (core_reset),
      .sram_save_stb      (sram_save_stb),
      .sram_load_stb      (sram_load_stb),
      .forced_scandoubler (forced_scandoubler),
      .hdmi_width         (hdmi_width),
      .hdmi_height        (hdmi_height),
      .video_cfg          (video_cfg),
      .img_mounted_stb    (img_mounted_stb),
      .img_size           (img_size),
      .spi_clk            (spi_clk),
      .spi_mosi           (spi_mosi),
      .sd_miso            (sd_miso),
      .vsd_miso           (vsd_miso),
      .sd_pins            (sd_pins),
      .sd_miso_core       (sd_miso_core),
      .leds               (leds),
      .ioctl_download     (ioctl_download),
      .ioctl_index        (ioctl_index),
      .motor              (motor),
      .cas_dout           (cas_dout),
      .tape_adc           (tape_adc),
      .tape_adc_act       (tape_adc_act),
      .dl_active          (dl_active),
      .dl_req             (dl_req),
      .cas_req            (cas_req),
      .cas_enable         (cas_enable),
      .play               (play),
      .rewind             (rewind),
      .tape_in            (tape_in),
      .ddr_req            (ddr_req)
   );

   initial begin
      clock_bus = 1'b0;
      forever #5 clock_bus = ~clock_bus;
   end

   initial begin
      #(WATCHDOG_CYCLES * 10);
      $display("watchdog expired after %0d cycles, the run never finished", WATCHDOG_CYCLES);
      $display("tests failed");
      $finish;
   end

   // ========================================
   // Helpers
   // ========================================
   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // Inputs change 1 ns after the rising edge
   task automatic next_cycle();
      @(posedge clock_bus);
      #1;
   endtask

   task automatic check_value(input string name, input int row, input logic [63:0] got,
                              input logic [63:0] exp);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("ERR %s row %0d: got %h expected %h", name, row, got, exp);
      end
   endtask

   task automatic print_result(input string name, input int rows, input int first_errors);
      $display("%-10s %3d rows  %0d errors", name, rows, errors - first_errors);
   endtask

   // Wait for a run of dark cycles since the LEDs lag a change by two clocks
   task automatic wait_leds_dark(input int row);
      int n;
      int streak;
      n = 0;
      streak = 0;
      while (streak < 3 && n < 4 * ACT_TIMEOUT) begin
         next_cycle();
         streak = (leds.user || leds.disk[0]) ? 0 : streak + 1;
         n++;
      end
      checks++;
      assert (streak >= 3) else begin
         errors++;
         $display("activity LEDs never went dark before activity row %0d", row);
      end
   endtask

   // ========================================
   // Behaviors
   // ========================================
   task automatic apply_video_rows();
      int first;
      first = errors;
      for (int i = 0; i < VIDEO_ROWS; i++) begin
         status = '0;
         status[`ST_ASPECT_LO +: 2] = video_tbl[i].ar;
         status[`ST_SCALE_LO +: 3]  = video_tbl[i].scale;
         hdmi_width         = video_tbl[i].width;
         hdmi_height        = video_tbl[i].height;
         forced_scandoubler = video_tbl[i].forced;
         next_cycle();
         check_value("video_cfg", i, 64'(video_cfg), 64'(video_tbl[i].exp));
      end
      status = '0;
      forced_scandoubler = 1'b0;
      print_result("video", VIDEO_ROWS, first);
   endtask

   task automatic check_reset_strobes();
      int first;
      first = errors;
      for (int i = 0; i < STROBE_ROWS; i++) begin
         status = '0;
         {reset, upload_reset, load_sram, status[`ST_RESET], status[`ST_DETACH],
          status[`ST_SRAM_SAVE], status[`ST_SRAM_LOAD]} = strobe_tbl[i].drive;
         next_cycle();
         check_value("core_reset", i, 64'(core_reset), 64'(strobe_tbl[i].exp[2]));
         check_value("sram_save_stb", i, 64'(sram_save_stb), 64'(strobe_tbl[i].exp[1]));
         check_value("sram_load_stb", i, 64'(sram_load_stb), 64'(strobe_tbl[i].exp[0]));
      end
      status = '0;
      reset = 1'b0;
      upload_reset = 1'b0;
      load_sram = 1'b0;
      print_result("strobes", STROBE_ROWS, first);
   endtask

   task automatic route_sd_card();
      int       first;
      sd_pins_t exp_pins;
      logic     exp_miso;
      first = errors;
      for (int i = 0; i < SD_ROWS; i++) begin
         img_mounted_stb = sd_tbl[i].mount;
         img_size        = sd_tbl[i].size;
         next_cycle();
         img_mounted_stb = 1'b0;
         rng = xorshift32(rng);
         {spi_clk, spi_mosi, sd_miso, vsd_miso} = rng[3:0];
         #1;
         // Image selected means the physical card sees no clock or data
         exp_pins = sd_tbl[i].exp_sel ? 3'b100 : {1'b0, spi_clk, spi_mosi};
         exp_miso = sd_tbl[i].exp_sel ? vsd_miso : sd_miso;
         check_value("sd_pins", i, 64'(sd_pins), 64'(exp_pins));
         check_value("sd_miso_core", i, 64'(sd_miso_core), 64'(exp_miso));
         check_value("leds.disk[1]", i, 64'(leds.disk[1]), 64'h1);
         check_value("leds.power", i, 64'(leds.power), 64'h0);
         next_cycle();
      end
      print_result("sd_route", SD_ROWS, first);
   endtask

   task automatic measure_activity();
      int    first;
      logic  act_led;
      logic  idle_led;
      string act_name;
      string idle_name;
      first = errors;
      spi_clk  = 1'b0;
      sd_miso  = 1'b0;
      vsd_miso = 1'b0;
      for (int i = 0; i < ACT_ROWS; i++) begin
         if (act_tbl[i].sel) begin
            act_name  = "leds.user";
            idle_name = "leds.disk[0]";
         end else begin
            act_name  = "leds.disk[0]";
            idle_name = "leds.user";
         end
         img_mounted_stb = 1'b1;
         img_size = act_tbl[i].sel ? 64'h4000 : 64'h0;
         next_cycle();
         img_mounted_stb = 1'b0;
         wait_leds_dark(i);
         spi_mosi = ~spi_mosi;
         for (int n = 1; n <= int'(act_tbl[i].low_at); n++) begin
            next_cycle();
            act_led  = act_tbl[i].sel ? leds.user : leds.disk[0];
            idle_led = act_tbl[i].sel ? leds.disk[0] : leds.user;
            check_value(idle_name, i, 64'(idle_led), 64'h0);
            if (n >= int'(act_tbl[i].hi_from) && n <= int'(act_tbl[i].hi_to)) begin
               check_value(act_name, i, 64'(act_led), 64'h1);
            end
            if (n == int'(act_tbl[i].low_at)) begin
               check_value(act_name, i, 64'(act_led), 64'h0);
            end
         end
      end
      print_result("activity", ACT_ROWS, first);
   endtask

   task automatic exercise_cassette();
      int first;
      first = errors;
      for (int i = 0; i < CAS_ROWS; i++) begin
         status = '0;
         ioctl_download = cas_tbl[i].download;
         ioctl_index    = cas_tbl[i].index;
         {motor, status[`ST_TAPE_REWIND], status[`ST_RESET], status[`ST_TAPE_ADC],
          cas_dout, tape_adc, tape_adc_act} = cas_tbl[i].ctl;
         #1;
         check_value("cas_enable", i, 64'(cas_enable), 64'(cas_tbl[i].exp[3]));
         check_value("play", i, 64'(play), 64'(cas_tbl[i].exp[2]));
         check_value("rewind", i, 64'(rewind), 64'(cas_tbl[i].exp[1]));
         check_value("tape_in", i, 64'(tape_in), 64'(cas_tbl[i].exp[0]));
         next_cycle();
      end
      status = '0;
      print_result("cassette", CAS_ROWS, first);
   endtask

   task automatic arbitrate_ddr();
      int first;
      first = errors;
      for (int i = 0; i < DDR_ROWS; i++) begin
         dl_active = ddr_tbl[i].active;
         dl_req    = ddr_tbl[i].dl;
         cas_req   = ddr_tbl[i].cas;
         #1;
         check_value("ddr_req", i, 64'(ddr_req), 64'(ddr_tbl[i].exp));
         next_cycle();
      end
      print_result("ddr_arb", DDR_ROWS, first);
   endtask

   // ========================================
   // Main sequence
   // ========================================
   initial begin
      reset              = 1'b1;
      status             = '0;
      upload_reset       = 1'b0;
      load_sram          = 1'b0;
      forced_scandoubler = 1'b0;
      hdmi_width         = 12'd0;
      hdmi_height        = 12'd0;
      img_mounted_stb    = 1'b0;
      img_size           = '0;
      spi_clk            = 1'b0;
      spi_mosi           = 1'b0;
      sd_miso            = 1'b0;
      vsd_miso           = 1'b0;
      ioctl_download     = 1'b0;
      ioctl_index        = 16'd0;
      motor              = 1'b1;
      cas_dout           = 1'b0;
      tape_adc           = 1'b0;
      tape_adc_act       = 1'b0;
      dl_active          = 1'b0;
      dl_req             = '0;
      cas_req            = '0;
      checks             = 0;
      errors             = 0;
      rng                = 32'h9af5;

      // Random request pairs with the loader winning whenever it is active
      for (int i = 0; i < DDR_ROWS; i++) begin
         rng = xorshift32(rng);
         ddr_tbl[i].dl = {rng[27:0], rng[31]};
         rng = xorshift32(rng);
         ddr_tbl[i].cas = {rng[27:0], rng[31]};
         rng = xorshift32(rng);
         ddr_tbl[i].active = rng[4];
         ddr_tbl[i].exp = ddr_tbl[i].active ? ddr_tbl[i].dl : ddr_tbl[i].cas;
      end

      repeat (3) @(posedge clock_bus);
      #1;
      reset = 1'b0;

      apply_video_rows();
      check_reset_strobes();
      route_sd_card();
      measure_activity();
      exercise_cassette();
      arbitrate_ddr();

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== msx_frontend.f ====
+incdir+verilog
verilog/msx_frontend_pkg.sv
verilog/status_decode.sv
verilog/video_scaler_setup.sv
verilog/sd_card_router.sv
verilog/cassette_control.sv
verilog/msx_frontend.sv
bench/tb_msx_frontend.sv

// ==== Makefile ====
# Verilator build and run of the MSX frontend testbench

VERILATOR ?= verilator
TOP       ?= tb_msx_frontend
FLIST     ?= msx_frontend.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= all tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
